// File: all.f
+incdir+common
common/coherencePkg.sv
hw/requestIntake.sv
cacheCtrl/stateArray.sv
cacheCtrl/mesifProtocol.sv
cacheCtrl/coherenceUpdate.sv
hw/coherenceNode.sv
tests/coherenceNode_sva.sv
tests/coherenceNode_tb.sv

// File: tests/coherenceNode_tb.sv
`timescale 1ns/1ps
`include "coherence_macros.svh"

module coherenceNode_tb
	import coherencePkg::*;
();
	localparam int ADDR_WIDTH = `TAG_WIDTH + `INDEX_WIDTH;
	localparam int RANDOM_OPS = 300;
	localparam int TIMEOUT_CYCLES = 2000; // Directed part and 300 random operations need under 1000

	logic                  clk;
	logic                  rst;
	logic                  cpuValid;
	logic                  cpuWrite;
	logic [ADDR_WIDTH-1:0] cpuAddr;
	logic                  cpuCredit;
	logic                  snoopValid;
	busCommand             snoopCommand;
	logic [ADDR_WIDTH-1:0] snoopAddr;
	logic                  sharedIn;
	logic                  cplValid;
	logic                  cplSnoop;
	logic [ADDR_WIDTH-1:0] cplAddr;
	lineState              cplOldState;
	lineState              cplNewState;
	logic                  busValid;
	busCommand             busCmd;
	logic [ADDR_WIDTH-1:0] busAddr;
	logic                  writeBackValid;
	logic [ADDR_WIDTH-1:0] writeBackAddr;
	logic                  supplyData;
	logic                  sharedOut;
	logic                  ramWriteRequired;
	int                    credits;
	int                    cycleCount;
	int                    cpuDone = 0;
	int                    snoopDone = 0;
	int                    errorCount;
	integer                seed;

	coherenceNode dut0 (.*);

	bind coherenceNode coherenceNode_sva sva0 (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (!rst && cplValid) begin
			if (cplSnoop) begin
				snoopDone <= snoopDone + 1;
			end else begin
				cpuDone <= cpuDone + 1;
			end
		end
	end

	// A credit pulse is seen at the edge after the cycle it was raised in
	task automatic tick();
		@(posedge clk);
		if (cpuCredit) begin
			credits++;
		end
		cpuValid <= 1'b0;
		snoopValid <= 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			tick();
		end
	endtask

	task automatic sendCpu(input logic write, input logic [ADDR_WIDTH-1:0] addr);
		tick();
		while (credits == 0) begin
			tick();
		end
		cpuValid <= 1'b1;
		cpuWrite <= write;
		cpuAddr <= addr;
		credits--;
	endtask

	// Joins the current cycle, so a CPU request sent just before shares it
	task automatic addSnoop(input busCommand cmd, input logic [ADDR_WIDTH-1:0] addr);
		snoopValid <= 1'b1;
		snoopCommand <= cmd;
		snoopAddr <= addr;
	endtask

	task automatic sendSnoop(input busCommand cmd, input logic [ADDR_WIDTH-1:0] addr);
		tick();
		addSnoop(cmd, addr);
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [31:0]           r;
		logic [ADDR_WIDTH-1:0] cpuA;
		logic [ADDR_WIDTH-1:0] snA;
		busCommand             cmd;
		clk = 1'b0;
		rst = 1'b1;
		cpuValid = 1'b0;
		cpuWrite = 1'b0;
		cpuAddr = '0;
		snoopValid = 1'b0;
		snoopCommand = BUS_NONE;
		snoopAddr = '0;
		sharedIn = 1'b0;
		credits = 0;
		seed = 32'hd775;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		credits = `CREDIT_COUNT;

		sendCpu(1'b0, 12'h3C1); // Exclusive fill, read hit, silent upgrade
		sendCpu(1'b0, 12'h3C1);
		sendCpu(1'b1, 12'h3C1);
		sendSnoop(BUS_READ, 12'h3C1);
		sharedIn <= 1'b1;
		sendCpu(1'b0, 12'hA52); // Forward fill while another node holds the line
		idle(3);
		sharedIn <= 1'b0;
		sendCpu(1'b1, 12'hA52);
		sendSnoop(BUS_READ_EXCLUSIVE, 12'hA52);
		sendCpu(1'b1, 12'h3C3);
		sendSnoop(BUS_READ, 12'hA53); // Other tag, so the line stays as it is
		sendSnoop(BUS_INVALIDATE, 12'h3C3);
		sendCpu(1'b1, 12'h3C0);
		sendCpu(1'b0, 12'hA50); // Dirty victim goes back to memory
		idle(6);

		sendCpu(1'b1, 12'h3C1);
		sendCpu(1'b0, 12'h3C1);
		sendCpu(1'b1, 12'h3C1);
		sendCpu(1'b0, 12'h3C1);
		sendSnoop(BUS_READ, 12'h3C1); // These snoops pass the buffered requests
		sendSnoop(BUS_INVALIDATE, 12'h3C1);
		sendCpu(1'b0, 12'h3C1);
		addSnoop(BUS_READ, 12'h3C1);
		idle(8);

		for (int n = 0; n < RANDOM_OPS; n++) begin
			r = $random(seed);
			cpuA = {(r[8] ? 8'h3C : 8'hA5), 2'b00, r[10:9]};
			snA = {(r[12] ? 8'h3C : 8'hA5), 2'b00, r[14:13]};
			case (r[7:6])
				2'd0: cmd = BUS_READ;
				2'd1: cmd = BUS_READ_EXCLUSIVE;
				2'd2: cmd = BUS_INVALIDATE;
				default: cmd = r[11] ? BUS_WRITEBACK : BUS_NONE;
			endcase
			sharedIn <= r[15];
			case (r[2:0])
				3'd3, 3'd4: sendSnoop(cmd, snA);
				3'd5: begin
					sendCpu(r[3], cpuA);
					addSnoop(cmd, snA);
				end
				3'd6: idle(1);
				default: sendCpu(r[3], cpuA);
			endcase
		end

		tick();
		while (credits != `CREDIT_COUNT) begin
			tick();
		end
		idle(4); // Issued requests leave the pipeline within two cycles
		errorCount = dut0.sva0.failCount;
		$display("Completions: %0d CPU, %0d snoop; assertion failures: %0d",
			cpuDone, snoopDone, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule : coherenceNode_tb

// File: tests/coherenceNode_sva.sv
`timescale 1ns/1ps
`include "coherence_macros.svh"

module coherenceNode_sva
	import coherencePkg::*;
(
	input logic                               clk,
	input logic                               rst,
	input logic                               cpuValid,
	input logic                               cpuWrite,
	input logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] cpuAddr,
	input logic                               cpuCredit,
	input logic                               snoopValid,
	input busCommand                          snoopCommand,
	input logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] snoopAddr,
	input logic                               sharedIn,
	input logic                               cplValid,
	input logic                               cplSnoop,
	input logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] cplAddr,
	input lineState                           cplOldState,
	input lineState                           cplNewState,
	input logic                               busValid,
	input busCommand                          busCmd,
	input logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] busAddr,
	input logic                               writeBackValid,
	input logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] writeBackAddr,
	input logic                               supplyData,
	input logic                               sharedOut,
	input logic                               ramWriteRequired
);
	localparam int LINES = 1 << `INDEX_WIDTH;

	int                                 failCount = 0;
	logic [`TAG_WIDTH-1:0]              modelTag [LINES];
	lineState                           modelState [LINES];
	logic                               writeHist [8];
	logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] addrHist [8];
	logic [2:0]                         pushPtr;
	logic [2:0]                         popPtr;
	int                                 outstanding;
	busCommand                          snoopCmdD1;
	busCommand                          snoopCmdD2;
	logic                               sharedD1;
	logic [`INDEX_WIDTH-1:0]            cplIndex;
	logic                               tagMatch;
	logic                               victim;
	logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] victimAddr;
	lineState                           expOld;
	lineState                           expNew;
	busCommand                          expBus;
	logic [2:0]                         expFlags;

	function automatic string stateText(input lineState s);
		return s.name();
	endfunction

	function automatic string cmdText(input busCommand c);
		return c.name();
	endfunction

	task automatic reportWrongValue(input string name, input string expected, input string actual);
		failCount++;
		$error("MISMATCH time=%0t %s expected=%s actual=%s", $time, name, expected, actual);
	endtask

	task automatic reportViolation(input string what);
		failCount++;
		$error("Time %0t: %s", $time, what);
	endtask

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < LINES; i++) begin
				modelTag[i] <= '0;
				modelState[i] <= INVALID;
			end
			pushPtr <= '0;
			popPtr <= '0;
			outstanding <= 0;
		end else begin
			if (cplValid && (!cplSnoop || tagMatch)) begin // Snoop misses leave the line alone
				modelTag[cplIndex] <= cplAddr[`TAG_WIDTH+`INDEX_WIDTH-1:`INDEX_WIDTH];
				modelState[cplIndex] <= expNew;
			end
			if (cpuValid) begin
				writeHist[pushPtr] <= cpuWrite;
				addrHist[pushPtr] <= cpuAddr;
				pushPtr <= pushPtr + 1'b1;
			end
			if (cplValid && !cplSnoop) begin
				popPtr <= popPtr + 1'b1; // CPU requests complete in order
			end
			outstanding <= outstanding + (cpuValid ? 1 : 0) - (cpuCredit ? 1 : 0);
		end
	end

	// The decision sees the snoop command and sharedIn of the lookup cycle
	always_ff @(posedge clk) begin
		snoopCmdD1 <= snoopCommand;
		snoopCmdD2 <= snoopCmdD1;
		sharedD1 <= sharedIn;
	end

	always_comb begin
		cplIndex = cplAddr[`INDEX_WIDTH-1:0];
		tagMatch = modelTag[cplIndex] == cplAddr[`TAG_WIDTH+`INDEX_WIDTH-1:`INDEX_WIDTH];
		victim = !cplSnoop && !tagMatch && (modelState[cplIndex] == MODIFIED);
		victimAddr = {modelTag[cplIndex], cplIndex};
		expOld = tagMatch ? modelState[cplIndex] : INVALID;
		expNew = expOld;
		expBus = BUS_NONE;
		expFlags = '0;
		if (cplSnoop) begin
			if (expOld != INVALID) begin
				case (snoopCmdD2)
					BUS_READ: expNew = SHARED;
					BUS_READ_EXCLUSIVE, BUS_INVALIDATE: expNew = INVALID;
					default: expNew = expOld;
				endcase
			end
			expFlags = {(expOld inside {MODIFIED, EXCLUSIVE, FORWARD}), (expOld != INVALID),
				(expOld == MODIFIED) && (snoopCmdD2 == BUS_READ)};
		end else if (writeHist[popPtr]) begin
			expNew = MODIFIED;
			case (expOld)
				INVALID: expBus = BUS_READ_EXCLUSIVE;
				SHARED, FORWARD: expBus = BUS_INVALIDATE;
				default: expBus = BUS_NONE; // Exclusive and modified lines upgrade silently
			endcase
		end else if (expOld == INVALID) begin
			expNew = sharedD1 ? FORWARD : EXCLUSIVE;
			expBus = BUS_READ;
		end
	end

	resetIdle: assert property (@(posedge clk)
		rst |=> !cplValid && !busValid && !writeBackValid && !cpuCredit)
		else reportViolation("a completion, bus or credit output was active right after reset");

	creditReturn: assert property (@(posedge clk) disable iff (rst)
		cpuCredit |-> outstanding > 0)
		else reportViolation("a credit came back with no CPU request in the buffer");

	creditTiming: assert property (@(posedge clk) disable iff (rst)
		cpuCredit |-> ##2 (cplValid && !cplSnoop))
		else reportViolation("a returned credit was not followed by a CPU completion two cycles later");

	cplAddrCheck: assert property (@(posedge clk) disable iff (rst)
		(cplValid && !cplSnoop) |-> cplAddr == addrHist[popPtr])
		else reportWrongValue("cplAddr", $sformatf("%h", $sampled(addrHist[popPtr])),
			$sformatf("%h", $sampled(cplAddr)));

	oldStateCheck: assert property (@(posedge clk) disable iff (rst)
		cplValid |-> cplOldState == expOld)
		else reportWrongValue("cplOldState", stateText($sampled(expOld)),
			stateText($sampled(cplOldState)));

	newStateCheck: assert property (@(posedge clk) disable iff (rst)
		cplValid |-> cplNewState == expNew)
		else reportWrongValue("cplNewState", stateText($sampled(expNew)),
			stateText($sampled(cplNewState)));

	busValidCheck: assert property (@(posedge clk) disable iff (rst)
		busValid == (cplValid && (expBus != BUS_NONE)))
		else reportWrongValue("busValid", $sformatf("%b", $sampled(cplValid && (expBus != BUS_NONE))),
			$sformatf("%b", $sampled(busValid)));

	busCmdCheck: assert property (@(posedge clk) disable iff (rst)
		busValid |-> busCmd == expBus)
		else reportWrongValue("busCmd", cmdText($sampled(expBus)), cmdText($sampled(busCmd)));

	busAddrCheck: assert property (@(posedge clk) disable iff (rst)
		busValid |-> busAddr == addrHist[popPtr])
		else reportWrongValue("busAddr", $sformatf("%h", $sampled(addrHist[popPtr])),
			$sformatf("%h", $sampled(busAddr)));

	snoopFlagCheck: assert property (@(posedge clk) disable iff (rst)
		(cplValid && cplSnoop) |-> {supplyData, sharedOut, ramWriteRequired} == expFlags)
		else reportWrongValue("{supplyData,sharedOut,ramWriteRequired}",
			$sformatf("%b", $sampled(expFlags)),
			$sformatf("%b", $sampled({supplyData, sharedOut, ramWriteRequired})));

	snoopLatency: assert property (@(posedge clk) disable iff (rst)
		snoopValid |-> ##2 (cplValid && cplSnoop && (cplAddr == $past(snoopAddr, 2))))
		else reportViolation("a snoop did not complete exactly two cycles after it was sampled");

	writeBackValidCheck: assert property (@(posedge clk) disable iff (rst)
		writeBackValid == (cplValid && victim))
		else reportWrongValue("writeBackValid", $sformatf("%b", $sampled(cplValid && victim)),
			$sformatf("%b", $sampled(writeBackValid)));

	writeBackAddrCheck: assert property (@(posedge clk) disable iff (rst)
		writeBackValid |-> writeBackAddr == victimAddr)
		else reportWrongValue("writeBackAddr", $sformatf("%h", $sampled(victimAddr)),
			$sformatf("%h", $sampled(writeBackAddr)));

endmodule : coherenceNode_sva

// File: hw/coherenceNode.sv
`timescale 1ns/1ps
`include "coherence_macros.svh"

module coherenceNode
	import coherencePkg::*;
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cpuValid,
	input  logic                                cpuWrite,
	input  logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  cpuAddr,
	output logic                                cpuCredit,
	input  logic                                snoopValid,
	input  busCommand                           snoopCommand,
	input  logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  snoopAddr,
	input  logic                                sharedIn,
	output logic                                cplValid,
	output logic                                cplSnoop,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  cplAddr,
	output lineState                            cplOldState,
	output lineState                            cplNewState,
	output logic                                busValid,
	output busCommand                           busCmd,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  busAddr,
	output logic                                writeBackValid,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  writeBackAddr,
	output logic                                supplyData,
	output logic                                sharedOut,
	output logic                                ramWriteRequired
);
	logic                               issueValid;
	logic                               issueSnoop;
	logic                               issueWrite;
	busCommand                          issueCommand;
	logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] issueAddr;
	logic                               lookValid;
	logic                               lookSnoop;
	logic                               lookWrite;
	busCommand                          lookCommand;
	logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] lookAddr;
	lineState                           lookState;
	logic [`TAG_WIDTH-1:0]              lookTag;
	lineState                           nextState;
	busCommand                          cpuBusCommand;
	logic                               writeBackRequired;
	logic                               decSupplyData;
	logic                               decSharedOut;
	logic                               decRamWriteRequired;
	logic                               wrValid;
	logic [`INDEX_WIDTH-1:0]            wrIndex;
	logic [`TAG_WIDTH-1:0]              wrTag;
	lineState                           wrState;

	requestIntake intake0 (
		.clk(clk), .rst(rst),
		.cpuValid(cpuValid), .cpuWrite(cpuWrite), .cpuAddr(cpuAddr),
		.snoopValid(snoopValid), .snoopCommand(snoopCommand), .snoopAddr(snoopAddr),
		.cpuCredit(cpuCredit),
		.issueValid(issueValid), .issueSnoop(issueSnoop), .issueWrite(issueWrite),
		.issueCommand(issueCommand), .issueAddr(issueAddr)
	);

	stateArray array0 (
		.clk(clk), .rst(rst),
		.issueValid(issueValid), .issueSnoop(issueSnoop), .issueWrite(issueWrite),
		.issueCommand(issueCommand), .issueAddr(issueAddr),
		.wrValid(wrValid), .wrIndex(wrIndex), .wrTag(wrTag), .wrState(wrState),
		.lookValid(lookValid), .lookSnoop(lookSnoop), .lookWrite(lookWrite),
		.lookCommand(lookCommand), .lookAddr(lookAddr), .lookState(lookState),
		.lookTag(lookTag)
	);

	mesifProtocol protocol0 (
		.lookSnoop(lookSnoop), .lookWrite(lookWrite), .lookCommand(lookCommand),
		.lookState(lookState), .lookTag(lookTag), .lookAddr(lookAddr),
		.sharedIn(sharedIn),
		.nextState(nextState), .cpuBusCommand(cpuBusCommand),
		.writeBackRequired(writeBackRequired), .supplyData(decSupplyData),
		.sharedOut(decSharedOut), .ramWriteRequired(decRamWriteRequired)
	);

	coherenceUpdate update0 (
		.clk(clk), .rst(rst),
		.lookValid(lookValid), .lookSnoop(lookSnoop), .lookWrite(lookWrite),
		.lookCommand(lookCommand), .lookAddr(lookAddr), .lookState(lookState),
		.lookTag(lookTag),
		.nextState(nextState), .cpuBusCommand(cpuBusCommand),
		.writeBackRequired(writeBackRequired), .decSupplyData(decSupplyData),
		.decSharedOut(decSharedOut), .decRamWriteRequired(decRamWriteRequired),
		.wrValid(wrValid), .wrIndex(wrIndex), .wrTag(wrTag), .wrState(wrState),
		.cplValid(cplValid), .cplSnoop(cplSnoop), .cplAddr(cplAddr),
		.cplOldState(cplOldState), .cplNewState(cplNewState),
		.busValid(busValid), .busCmd(busCmd), .busAddr(busAddr),
		.writeBackValid(writeBackValid), .writeBackAddr(writeBackAddr),
		.supplyData(supplyData), .sharedOut(sharedOut),
		.ramWriteRequired(ramWriteRequired)
	);

endmodule : coherenceNode

// File: cacheCtrl/coherenceUpdate.sv
`timescale 1ns/1ps
`include "coherence_macros.svh"

module coherenceUpdate
	import coherencePkg::*;
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                lookValid,
	input  logic                                lookSnoop,
	input  logic                                lookWrite,
	input  busCommand                           lookCommand,
	input  logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  lookAddr,
	input  lineState                            lookState,
	input  logic [`TAG_WIDTH-1:0]               lookTag,
	input  lineState                            nextState,
	input  busCommand                           cpuBusCommand,
	input  logic                                writeBackRequired,
	input  logic                                decSupplyData,
	input  logic                                decSharedOut,
	input  logic                                decRamWriteRequired,
	output logic                                wrValid,
	output logic [`INDEX_WIDTH-1:0]             wrIndex,
	output logic [`TAG_WIDTH-1:0]               wrTag,
	output lineState                            wrState,
	output logic                                cplValid,
	output logic                                cplSnoop,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  cplAddr,
	output lineState                            cplOldState,
	output lineState                            cplNewState,
	output logic                                busValid,
	output busCommand                           busCmd,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  busAddr,
	output logic                                writeBackValid,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  writeBackAddr,
	output logic                                supplyData,
	output logic                                sharedOut,
	output logic                                ramWriteRequired
);
	logic tagHit;

	assign tagHit = lookAddr[`TAG_WIDTH+`INDEX_WIDTH-1:`INDEX_WIDTH] == lookTag;

	// Snoops to another tag or without a command leave the line as it is
	assign wrValid = lookValid && (!lookSnoop || (tagHit && (lookCommand != BUS_NONE)));
	assign wrIndex = lookAddr[`INDEX_WIDTH-1:0];
	assign wrTag = lookAddr[`TAG_WIDTH+`INDEX_WIDTH-1:`INDEX_WIDTH];
	assign wrState = nextState;

	always_ff @(posedge clk) begin
		if (rst) begin
			cplValid <= 1'b0;
			busValid <= 1'b0;
			writeBackValid <= 1'b0;
			supplyData <= 1'b0;
			sharedOut <= 1'b0;
			ramWriteRequired <= 1'b0;
		end else begin
			cplValid <= lookValid;
			busValid <= lookValid && (cpuBusCommand != BUS_NONE);
			writeBackValid <= lookValid && writeBackRequired;
			supplyData <= lookValid && decSupplyData;
			sharedOut <= lookValid && decSharedOut;
			ramWriteRequired <= lookValid && decRamWriteRequired;
		end
	end

	always_ff @(posedge clk) begin
		cplSnoop <= lookSnoop;
		cplAddr <= lookAddr;
		cplOldState <= tagHit ? lookState : INVALID; // A victim is not the old state of this line
		cplNewState <= nextState;
		busCmd <= cpuBusCommand;
		busAddr <= lookAddr;
		writeBackAddr <= {lookTag, lookAddr[`INDEX_WIDTH-1:0]};
	end

endmodule : coherenceUpdate

// File: cacheCtrl/mesifProtocol.sv
`timescale 1ns/1ps
`include "coherence_macros.svh"

module mesifProtocol
	import coherencePkg::*;
(
	input  logic                                lookSnoop,
	input  logic                                lookWrite,
	input  busCommand                           lookCommand,
	input  lineState                            lookState,
	input  logic [`TAG_WIDTH-1:0]               lookTag,
	input  logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  lookAddr,
	input  logic                                sharedIn,
	output lineState                            nextState,
	output busCommand                           cpuBusCommand,
	output logic                                writeBackRequired,
	output logic                                supplyData,
	output logic                                sharedOut,
	output logic                                ramWriteRequired
);
	logic     tagHit;
	lineState hitState;
	lineState cpuNext;
	busCommand cpuCommand;
	lineState snoopNext;

	assign tagHit = lookAddr[`TAG_WIDTH+`INDEX_WIDTH-1:`INDEX_WIDTH] == lookTag;
	assign hitState = tagHit ? lookState : INVALID; // A tag miss behaves like an invalid line

	// CPU side
	always_comb begin
		cpuNext = hitState;
		cpuCommand = BUS_NONE;
		case (hitState)
			INVALID: begin
				if (lookWrite) begin
					cpuNext = MODIFIED;
					cpuCommand = BUS_READ_EXCLUSIVE;
				end else begin
					cpuNext = sharedIn ? FORWARD : EXCLUSIVE; // Another node holds a copy
					cpuCommand = BUS_READ;
				end
			end

			SHARED, FORWARD: begin
				if (lookWrite) begin
					cpuNext = MODIFIED;
					cpuCommand = BUS_INVALIDATE;
				end
			end

			EXCLUSIVE: begin
				if (lookWrite) begin
					cpuNext = MODIFIED; // Silent upgrade, no other copies exist
				end
			end

			default: begin
				cpuNext = hitState;
			end
		endcase
	end

	assign cpuBusCommand = lookSnoop ? BUS_NONE : cpuCommand;

	// Only a dirty victim with another tag needs to go back to memory
	assign writeBackRequired = !lookSnoop && !tagHit && (lookState == MODIFIED);

	// Snoop side
	always_comb begin
		snoopNext = hitState;
		case (lookCommand)
			BUS_READ: begin
				if (hitState != INVALID) begin
					snoopNext = SHARED;
				end
			end

			BUS_READ_EXCLUSIVE, BUS_INVALIDATE: begin
				snoopNext = INVALID;
			end

			default: begin
				snoopNext = hitState;
			end
		endcase
	end

	assign supplyData = lookSnoop && (hitState inside {MODIFIED, EXCLUSIVE, FORWARD});
	assign sharedOut = lookSnoop && (hitState != INVALID);
	assign ramWriteRequired = lookSnoop && (hitState == MODIFIED) && (lookCommand == BUS_READ);

	assign nextState = lookSnoop ? snoopNext : cpuNext;

endmodule : mesifProtocol

// File: cacheCtrl/stateArray.sv
`timescale 1ns/1ps
`include "coherence_macros.svh"

module stateArray
	import coherencePkg::*;
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                issueValid,
	input  logic                                issueSnoop,
	input  logic                                issueWrite,
	input  busCommand                           issueCommand,
	input  logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  issueAddr,
	input  logic                                wrValid,
	input  logic [`INDEX_WIDTH-1:0]             wrIndex,
	input  logic [`TAG_WIDTH-1:0]               wrTag,
	input  lineState                            wrState,
	output logic                                lookValid,
	output logic                                lookSnoop,
	output logic                                lookWrite,
	output busCommand                           lookCommand,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  lookAddr,
	output lineState                            lookState,
	output logic [`TAG_WIDTH-1:0]               lookTag
);
	localparam int LINES = 1 << `INDEX_WIDTH;

	logic [`TAG_WIDTH-1:0]   tagMem [LINES];
	lineState                stateMem [LINES];
	logic [`INDEX_WIDTH-1:0] issueIndex;
	logic [`TAG_WIDTH-1:0]   issueTag;
	logic [`TAG_WIDTH-1:0]   storedTag;
	lineState                storedState;
	lineState                reportedState;

	assign issueIndex = issueAddr[`INDEX_WIDTH-1:0];
	assign issueTag = issueAddr[`TAG_WIDTH+`INDEX_WIDTH-1:`INDEX_WIDTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < LINES; i++) begin
				tagMem[i] <= '0;
				stateMem[i] <= INVALID;
			end
		end else if (wrValid) begin
			tagMem[wrIndex] <= wrTag;
			stateMem[wrIndex] <= wrState;
		end
	end

	// The update stage may be writing this very line right now
	always_comb begin
		if (wrValid && (wrIndex == issueIndex)) begin
			storedTag = wrTag;
			storedState = wrState;
		end else begin
			storedTag = tagMem[issueIndex];
			storedState = stateMem[issueIndex];
		end
	end

	// A CPU access keeps the victim state so a dirty line can be written back
	assign reportedState = ((storedTag == issueTag) || !issueSnoop) ? storedState : INVALID;

	always_ff @(posedge clk) begin
		if (rst) begin
			lookValid <= 1'b0;
		end else begin
			lookValid <= issueValid;
		end
	end

	always_ff @(posedge clk) begin
		lookSnoop <= issueSnoop;
		lookWrite <= issueWrite;
		lookCommand <= issueCommand;
		lookAddr <= issueAddr;
		lookState <= reportedState;
		lookTag <= storedTag; // Stored tag, not the requested one
	end

endmodule : stateArray

// File: hw/requestIntake.sv
`timescale 1ns/1ps
`include "coherence_macros.svh"

module requestIntake
	import coherencePkg::*;
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cpuValid,
	input  logic                                cpuWrite,
	input  logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  cpuAddr,
	input  logic                                snoopValid,
	input  busCommand                           snoopCommand,
	input  logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  snoopAddr,
	output logic                                cpuCredit,
	output logic                                issueValid,
	output logic                                issueSnoop,
	output logic                                issueWrite,
	output busCommand                           issueCommand,
	output logic [`TAG_WIDTH+`INDEX_WIDTH-1:0]  issueAddr
);
	localparam int PTR_WIDTH = $clog2(`CREDIT_COUNT);

	logic                               bufWrite [`CREDIT_COUNT];
	logic [`TAG_WIDTH+`INDEX_WIDTH-1:0] bufAddr [`CREDIT_COUNT];
	logic [PTR_WIDTH-1:0]               head;
	logic [PTR_WIDTH-1:0]               tail;
	logic [PTR_WIDTH:0]                 fillCount;
	logic                               cpuPop;

	assign cpuPop = (fillCount != '0) && !snoopValid; // Snoops always win the issue slot

	always_ff @(posedge clk) begin
		if (cpuValid) begin // The CPU only sends while it holds a credit
			bufWrite[tail] <= cpuWrite;
			bufAddr[tail] <= cpuAddr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			fillCount <= '0;
		end else begin
			if (cpuValid) begin
				tail <= (tail == PTR_WIDTH'(`CREDIT_COUNT - 1)) ? '0 : tail + 1'b1;
			end
			if (cpuPop) begin
				head <= (head == PTR_WIDTH'(`CREDIT_COUNT - 1)) ? '0 : head + 1'b1;
			end
			case ({cpuValid, cpuPop})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount;
			endcase
		end
	end

	assign cpuCredit = cpuPop; // One credit back per request leaving the buffer

	assign issueValid = snoopValid || (fillCount != '0);
	assign issueSnoop = snoopValid;
	assign issueWrite = snoopValid ? 1'b0 : bufWrite[head];
	assign issueCommand = snoopValid ? snoopCommand : BUS_NONE;
	assign issueAddr = snoopValid ? snoopAddr : bufAddr[head];

endmodule : requestIntake

// File: common/coherencePkg.sv
package coherencePkg;

	// Stable line states of the MESIF protocol
	typedef enum logic [2:0] {
		MODIFIED  = 3'd0,
		EXCLUSIVE = 3'd1,
		SHARED    = 3'd2,
		FORWARD   = 3'd3,
		INVALID   = 3'd4
	} lineState;

	// Commands seen on the snooping bus
	typedef enum logic [2:0] {
		BUS_NONE           = 3'd0,
		BUS_READ           = 3'd1,
		BUS_READ_EXCLUSIVE = 3'd2,
		BUS_INVALIDATE     = 3'd3,
		BUS_WRITEBACK      = 3'd4
	} busCommand;

endpackage : coherencePkg

// File: common/coherence_macros.svh
`ifndef COHERENCE_MACROS_SVH
`define COHERENCE_MACROS_SVH

// Line index width, 16 lines per node
`define INDEX_WIDTH 4

// Address tag width, a line address is the tag followed by the index
`define TAG_WIDTH 8

// CPU request credits, equal to the intake buffer depth
`define CREDIT_COUNT 4

`endif
